/* hw/decode_config.svh */
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Instruction word and register width
`define DECODE_DATA_WIDTH 16

// Register select field width
`define DECODE_SEL_WIDTH 3

// Architectural registers
`define DECODE_REG_COUNT 8

// Cycles from decode to register write, valid range 2 to 5
`define DECODE_WB_DELAY 3

`endif

/* hw/decode_pkg.sv */
`include "decode_config.svh"
`default_nettype none

package decode_pkg;

    // Major opcode, instruction bits 15..11
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_LBI   = 5'b11000,
        OP_RFMT  = 5'b11011
    } opcode_t;

    // Operation requested from the execute stage
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_XOR   = 3'd2,
        ALU_ANDN  = 3'd3,
        ALU_PASSB = 3'd4
    } aluOp_t;

    // Destination tag carried down the writeback chain
    typedef struct packed {
        logic                         regWrt;
        logic [`DECODE_SEL_WIDTH-1:0] rd;
    } wbTag_t;

endpackage

`default_nettype wire

/* hw/instrDecoder.sv */
`include "decode_config.svh"
`default_nettype none

module instrDecoder (
    input  wire logic [`DECODE_DATA_WIDTH-1:0] instr,
    input  wire logic                          nopMech,
    output decode_pkg::aluOp_t                 aluOp,
    output logic [`DECODE_DATA_WIDTH-1:0]      immExt,
    output logic                               immSel,
    output logic                               memRead,
    output logic                               memWrt,
    output logic                               isBranch,
    output logic                               halt,
    output logic                               illegal,
    output decode_pkg::wbTag_t                 tagOut
);

    // Destination field select
    localparam logic [1:0] DST_RT = 2'd0;
    localparam logic [1:0] DST_RS = 2'd1;
    localparam logic [1:0] DST_RD = 2'd2;

    // Immediate extension kinds
    localparam logic [1:0] IMM_NONE = 2'd0;
    localparam logic [1:0] IMM_5S   = 2'd1;
    localparam logic [1:0] IMM_5Z   = 2'd2;
    localparam logic [1:0] IMM_8S   = 2'd3;

    decode_pkg::opcode_t          opcode;
    logic                         regWrt;
    logic [1:0]                   dstSel;
    logic [1:0]                   immKind;
    logic [`DECODE_SEL_WIDTH-1:0] rd;

    // Override turns the slot into a bubble before lookup
    assign opcode = nopMech ? decode_pkg::OP_NOP : decode_pkg::opcode_t'(instr[15:11]);

    // Control table
    always_comb begin
        aluOp    = decode_pkg::ALU_ADD;
        immSel   = 1'b0;
        memRead  = 1'b0;
        memWrt   = 1'b0;
        isBranch = 1'b0;
        halt     = 1'b0;
        illegal  = 1'b0;
        regWrt   = 1'b0;
        dstSel   = DST_RT;
        immKind  = IMM_NONE;

        case (opcode)
            decode_pkg::OP_HALT: begin
                halt = 1'b1;
            end
            decode_pkg::OP_NOP: begin
                // Nothing to do
            end
            decode_pkg::OP_ADDI: begin
                aluOp   = decode_pkg::ALU_ADD;
                immSel  = 1'b1;
                regWrt  = 1'b1;
                immKind = IMM_5S;
            end
            decode_pkg::OP_SUBI: begin
                aluOp   = decode_pkg::ALU_SUB;
                immSel  = 1'b1;
                regWrt  = 1'b1;
                immKind = IMM_5S;
            end
            decode_pkg::OP_XORI: begin
                aluOp   = decode_pkg::ALU_XOR;
                immSel  = 1'b1;
                regWrt  = 1'b1;
                immKind = IMM_5Z;
            end
            decode_pkg::OP_ANDNI: begin
                aluOp   = decode_pkg::ALU_ANDN;
                immSel  = 1'b1;
                regWrt  = 1'b1;
                immKind = IMM_5Z;
            end
            decode_pkg::OP_BEQZ: begin
                isBranch = 1'b1;
                immKind  = IMM_8S;
            end
            decode_pkg::OP_ST: begin
                // Address is base plus offset
                immSel  = 1'b1;
                memWrt  = 1'b1;
                immKind = IMM_5S;
            end
            decode_pkg::OP_LD: begin
                immSel  = 1'b1;
                memRead = 1'b1;
                regWrt  = 1'b1;
                immKind = IMM_5S;
            end
            decode_pkg::OP_LBI: begin
                aluOp   = decode_pkg::ALU_PASSB;
                immSel  = 1'b1;
                regWrt  = 1'b1;
                dstSel  = DST_RS;
                immKind = IMM_8S;
            end
            decode_pkg::OP_RFMT: begin
                regWrt = 1'b1;
                dstSel = DST_RD;
                // Function field picks the operation
                case (instr[1:0])
                    2'b00:   aluOp = decode_pkg::ALU_ADD;
                    2'b01:   aluOp = decode_pkg::ALU_SUB;
                    2'b10:   aluOp = decode_pkg::ALU_XOR;
                    default: aluOp = decode_pkg::ALU_ANDN;
                endcase
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // Immediate extension
    always_comb begin
        case (immKind)
            IMM_5S:  immExt = {{(`DECODE_DATA_WIDTH-5){instr[4]}}, instr[4:0]};
            IMM_5Z:  immExt = {{(`DECODE_DATA_WIDTH-5){1'b0}}, instr[4:0]};
            IMM_8S:  immExt = {{(`DECODE_DATA_WIDTH-8){instr[7]}}, instr[7:0]};
            default: immExt = '0;
        endcase
    end

    // Destination field
    always_comb begin
        case (dstSel)
            DST_RS:  rd = instr[10:8];
            DST_RD:  rd = instr[4:2];
            default: rd = instr[7:5];
        endcase
    end

    // Tag is all zero when nothing is written
    always_comb begin
        tagOut.regWrt = regWrt;
        tagOut.rd     = regWrt ? rd : '0;
    end

endmodule

`default_nettype wire

/* hw/wbStage.sv */
`include "decode_config.svh"
`default_nettype none

module wbStage (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire decode_pkg::wbTag_t           tagIn,
    input  wire logic [`DECODE_SEL_WIDTH-1:0] rsSel,
    input  wire logic [`DECODE_SEL_WIDTH-1:0] rtSel,
    output decode_pkg::wbTag_t                tagOut,
    output logic                              match
);

    decode_pkg::wbTag_t heldTag;

    // One cycle of writeback delay
    always_ff @(posedge clk) begin
        if (rst) begin
            heldTag <= '0;
        end else begin
            heldTag <= tagIn;
        end
    end

    assign tagOut = heldTag;

    // Pending write to a register the current instruction reads
    always_comb begin
        match = 1'b0;
        if (heldTag.regWrt) begin
            if (heldTag.rd == rsSel || heldTag.rd == rtSel) begin
                match = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/regFileBypass.sv */
`include "decode_config.svh"
`default_nettype none

module regFileBypass (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [`DECODE_SEL_WIDTH-1:0]  rsSel,
    input  wire logic [`DECODE_SEL_WIDTH-1:0]  rtSel,
    input  wire decode_pkg::wbTag_t            wrTag,
    input  wire logic [`DECODE_DATA_WIDTH-1:0] wrData,
    input  wire logic [`DECODE_WB_DELAY-1:0]   stageMatch,
    output logic [`DECODE_DATA_WIDTH-1:0]      rsData,
    output logic [`DECODE_DATA_WIDTH-1:0]      rtData,
    output logic                               stall
);

    logic [`DECODE_DATA_WIDTH-1:0] regs [`DECODE_REG_COUNT];
    logic                          rsHit;
    logic                          rtHit;

    // Write port fed by the tag leaving the chain
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DECODE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrTag.regWrt) begin
            regs[wrTag.rd] <= wrData;
        end
    end

    // Same-cycle bypass on both read ports
    assign rsHit = wrTag.regWrt && (wrTag.rd == rsSel);
    assign rtHit = wrTag.regWrt && (wrTag.rd == rtSel);

    always_comb begin
        if (rsHit) begin
            rsData = wrData;
        end else begin
            rsData = regs[rsSel];
        end
    end

    always_comb begin
        if (rtHit) begin
            rtData = wrData;
        end else begin
            rtData = regs[rtSel];
        end
    end

    // The final stage is covered by the bypass above, so only the
    // earlier stages can hold a value the read ports cannot see yet
    assign stall = |stageMatch[`DECODE_WB_DELAY-2:0];

endmodule

`default_nettype wire

/* hw/decodeStage.sv */
`include "decode_config.svh"
`default_nettype none

module decodeStage (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [`DECODE_DATA_WIDTH-1:0] instr,
    input  wire logic                          nopMech,
    input  wire logic [`DECODE_DATA_WIDTH-1:0] wbData,
    output wire logic [`DECODE_DATA_WIDTH-1:0] rsData,
    output wire logic [`DECODE_DATA_WIDTH-1:0] rtData,
    output wire logic [`DECODE_DATA_WIDTH-1:0] immExt,
    output wire logic                          immSel,
    output wire decode_pkg::aluOp_t            aluOp,
    output wire logic                          memRead,
    output wire logic                          memWrt,
    output wire logic                          isBranch,
    output wire logic                          halt,
    output wire logic                          illegal,
    output wire logic                          stall,
    output wire logic                          wbRegWrt,
    output wire logic [`DECODE_SEL_WIDTH-1:0]  wbRd
);

    wire logic [`DECODE_SEL_WIDTH-1:0] rsSel;
    wire logic [`DECODE_SEL_WIDTH-1:0] rtSel;
    wire logic [`DECODE_WB_DELAY-1:0]  stageMatch;

    // Entry 0 is the decoder output, the last entry drains into the register file
    wire decode_pkg::wbTag_t tagChain [`DECODE_WB_DELAY+1];

    assign rsSel = instr[10:8];
    assign rtSel = instr[7:5];

    instrDecoder decoder (
        .instr    (instr),
        .nopMech  (nopMech),
        .aluOp    (aluOp),
        .immExt   (immExt),
        .immSel   (immSel),
        .memRead  (memRead),
        .memWrt   (memWrt),
        .isBranch (isBranch),
        .halt     (halt),
        .illegal  (illegal),
        .tagOut   (tagChain[0])
    );

    // Writeback delay chain
    for (genvar k = 0; k < `DECODE_WB_DELAY; k++) begin : gStage
        wbStage stage (
            .clk    (clk),
            .rst    (rst),
            .tagIn  (tagChain[k]),
            .rsSel  (rsSel),
            .rtSel  (rtSel),
            .tagOut (tagChain[k+1]),
            .match  (stageMatch[k])
        );
    end

    regFileBypass regFile (
        .clk        (clk),
        .rst        (rst),
        .rsSel      (rsSel),
        .rtSel      (rtSel),
        .wrTag      (tagChain[`DECODE_WB_DELAY]),
        .wrData     (wbData),
        .stageMatch (stageMatch),
        .rsData     (rsData),
        .rtData     (rtData),
        .stall      (stall)
    );

    // Write port visible outside for tracing
    assign wbRegWrt = tagChain[`DECODE_WB_DELAY].regWrt;
    assign wbRd     = tagChain[`DECODE_WB_DELAY].rd;

endmodule

`default_nettype wire

/* testbench/decodeStage_chk.sv */
`include "decode_config.svh"
`default_nettype none

module decodeStage_chk (
    input wire logic               clk,
    input wire logic               rst,
    input wire logic               nopMech,
    input wire logic               memRead,
    input wire logic               memWrt,
    input wire logic               illegal,
    input wire logic               stall,
    input wire decode_pkg::wbTag_t decTag
);

    timeunit 1ns;
    timeprecision 1ps;

    // A memory slot either loads or stores
    memExclusive: assert property (
        @(posedge clk) disable iff (rst) !(memRead && memWrt)
    ) else $error("memRead and memWrt are high in the same cycle");

    // Illegal opcodes leave no trace in the pipeline
    illegalQuiet: assert property (
        @(posedge clk) disable iff (rst)
        illegal |-> (!decTag.regWrt && !memRead && !memWrt)
    ) else $error("illegal instruction drives a write or memory access");

    // Bubble slot
    nopClearsTag: assert property (
        @(posedge clk) disable iff (rst)
        nopMech |-> (decTag == '0)
    ) else $error("nopMech active but the decoded tag is not cleared");

    // Chain is empty right after reset
    stallAfterReset: assert property (
        @(posedge clk) $fell(rst) |-> !stall
    ) else $error("stall high in the first cycle after reset");

endmodule

`default_nettype wire

/* testbench/tb_decodeStage.sv */
`include "decode_config.svh"
`default_nettype none

module tb_decodeStage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS = 29;
    localparam int RESET_CYCLES = 10;
    localparam int WATCHDOG_CYCLES = NUM_ROWS + RESET_CYCLES + `DECODE_WB_DELAY + 20;

    typedef logic [`DECODE_DATA_WIDTH-1:0] word_t;

    // One decode slot and the response expected for it
    typedef struct packed {
        word_t                        instr;
        logic                         nopMech;
        logic [2:0]                   flags;    // immSel, isBranch, halt
        decode_pkg::aluOp_t           aluOp;
        word_t                        immExt;
        logic [4:0]                   ctrl;     // memRead, memWrt, regWrt, illegal, stall
        logic [`DECODE_SEL_WIDTH-1:0] rd;
    } stimRow_t;

    logic                         clk;
    logic                         rst;
    word_t                        instr;
    logic                         nopMech;
    word_t                        wbData;
    word_t                        rsData;
    word_t                        rtData;
    word_t                        immExt;
    logic                         immSel;
    decode_pkg::aluOp_t           aluOp;
    logic                         memRead;
    logic                         memWrt;
    logic                         isBranch;
    logic                         halt;
    logic                         illegal;
    logic                         stall;
    logic                         wbRegWrt;
    logic [`DECODE_SEL_WIDTH-1:0] wbRd;

    stimRow_t           stimTable [NUM_ROWS];
    word_t              shadow [`DECODE_REG_COUNT];
    decode_pkg::wbTag_t tagQ [$];
    logic [31:0]        lfsrState;
    int                 rowIndex;
    int                 errorCount;

    always #5 clk = ~clk;

    decodeStage DUT (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .nopMech  (nopMech),
        .wbData   (wbData),
        .rsData   (rsData),
        .rtData   (rtData),
        .immExt   (immExt),
        .immSel   (immSel),
        .aluOp    (aluOp),
        .memRead  (memRead),
        .memWrt   (memWrt),
        .isBranch (isBranch),
        .halt     (halt),
        .illegal  (illegal),
        .stall    (stall),
        .wbRegWrt (wbRegWrt),
        .wbRd     (wbRd)
    );

    bind decodeStage decodeStage_chk chk (
        .clk     (clk),
        .rst     (rst),
        .nopMech (nopMech),
        .memRead (memRead),
        .memWrt  (memWrt),
        .illegal (illegal),
        .stall   (stall),
        .decTag  (tagChain[0])
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // One step per bit of write-back data
    task automatic drawWord(output word_t word);
        for (int b = 0; b < `DECODE_DATA_WIDTH; b++) begin
            lfsrState = lfsrNext(lfsrState);
            word[b] = lfsrState[0];
        end
    endtask

    task automatic checkValue(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            errorCount++;
            $display("** Error: row %0d %s = 0x%h, expected 0x%h",
                     rowIndex, name, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkRow(input stimRow_t row, input word_t word);
        decode_pkg::wbTag_t           wrTag;
        logic [`DECODE_SEL_WIDTH-1:0] rs;
        logic [`DECODE_SEL_WIDTH-1:0] rt;
        word_t                        expRs;
        word_t                        expRt;
        wrTag = tagQ[0];
        rs = row.instr[10:8];
        rt = row.instr[7:5];
        // Tag leaving the chain this cycle is visible through bypass
        expRs = (wrTag.regWrt && wrTag.rd == rs) ? word : shadow[rs];
        expRt = (wrTag.regWrt && wrTag.rd == rt) ? word : shadow[rt];
        if (row.ctrl[4] || row.ctrl[3] || row.ctrl[2]) begin
            checkValue("aluOp", word_t'(aluOp), word_t'(row.aluOp));
        end
        if (row.flags[2] || row.flags[1]) begin
            checkValue("immExt", immExt, row.immExt);
        end
        checkValue("immSel", word_t'(immSel), word_t'(row.flags[2]));
        checkValue("isBranch", word_t'(isBranch), word_t'(row.flags[1]));
        checkValue("halt", word_t'(halt), word_t'(row.flags[0]));
        checkValue("memRead", word_t'(memRead), word_t'(row.ctrl[4]));
        checkValue("memWrt", word_t'(memWrt), word_t'(row.ctrl[3]));
        checkValue("illegal", word_t'(illegal), word_t'(row.ctrl[1]));
        checkValue("stall", word_t'(stall), word_t'(row.ctrl[0]));
        checkValue("rsData", rsData, expRs);
        checkValue("rtData", rtData, expRt);
        checkValue("wbRegWrt", word_t'(wbRegWrt), word_t'(wrTag.regWrt));
        if (wrTag.regWrt) begin
            checkValue("wbRd", word_t'(wbRd), word_t'(wrTag.rd));
        end
    endtask

    // Register write at the end of the cycle, then shift the tag history
    task automatic updateModel(input stimRow_t row, input word_t word);
        decode_pkg::wbTag_t wrTag;
        decode_pkg::wbTag_t newTag;
        wrTag = tagQ.pop_front();
        if (wrTag.regWrt) begin
            shadow[wrTag.rd] = word;
        end
        newTag.regWrt = row.ctrl[2];
        newTag.rd = row.rd;
        tagQ.push_back(newTag);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Watchdog timeout: the stimulus table did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        stimRow_t           row;
        word_t              word;
        decode_pkg::wbTag_t zeroTag;
        clk = 1'b0;
        rst = 1'b1;
        // ADDI writing r0 while reset holds the chain
        instr = 16'h4000;
        nopMech = 1'b0;
        wbData = '0;
        errorCount = 0;
        rowIndex = 0;
        lfsrState = 32'hfa75ff4f;
        zeroTag = '0;
        for (int r = 0; r < `DECODE_REG_COUNT; r++) begin
            shadow[r] = '0;
        end
        repeat (`DECODE_WB_DELAY) tagQ.push_back(zeroTag);

        // instr, nopMech, flags, aluOp, immExt, ctrl, rd
        stimTable = '{
            '{16'h4025, 1'b0, 3'b100, decode_pkg::ALU_ADD,   16'h0005, 5'b00100, 3'd1},
            '{16'h4A5F, 1'b0, 3'b100, decode_pkg::ALU_SUB,   16'hFFFF, 5'b00100, 3'd2},
            '{16'h537F, 1'b0, 3'b100, decode_pkg::ALU_XOR,   16'h001F, 5'b00100, 3'd3},
            '{16'h5C90, 1'b0, 3'b100, decode_pkg::ALU_ANDN,  16'h0010, 5'b00100, 3'd4},
            '{16'h8AB0, 1'b0, 3'b100, decode_pkg::ALU_ADD,   16'hFFF0, 5'b10100, 3'd5},
            '{16'h81C3, 1'b0, 3'b100, decode_pkg::ALU_ADD,   16'h0003, 5'b01000, 3'd0},
            '{16'hC680, 1'b0, 3'b100, decode_pkg::ALU_PASSB, 16'hFF80, 5'b00100, 3'd6},
            '{16'hC77F, 1'b0, 3'b100, decode_pkg::ALU_PASSB, 16'h007F, 5'b00100, 3'd7},
            '{16'h66F0, 1'b0, 3'b010, decode_pkg::ALU_ADD,   16'hFFF0, 5'b00001, 3'd0},
            '{16'hD94C, 1'b0, 3'b000, decode_pkg::ALU_ADD,   16'h0000, 5'b00100, 3'd3},
            '{16'hDE71, 1'b0, 3'b000, decode_pkg::ALU_SUB,   16'h0000, 5'b00101, 3'd4},
            '{16'hDFA2, 1'b0, 3'b000, decode_pkg::ALU_XOR,   16'h0000, 5'b00100, 3'd0},
            '{16'hD897, 1'b0, 3'b000, decode_pkg::ALU_ANDN,  16'h0000, 5'b00101, 3'd5},
            '{16'h0B00, 1'b0, 3'b000, decode_pkg::ALU_ADD,   16'h0000, 5'b00001, 3'd0},
            '{16'h0500, 1'b0, 3'b001, decode_pkg::ALU_ADD,   16'h0000, 5'b00001, 3'd0},
            '{16'h4141, 1'b1, 3'b000, decode_pkg::ALU_ADD,   16'h0000, 5'b00000, 3'd0},
            '{16'h8A60, 1'b1, 3'b000, decode_pkg::ALU_ADD,   16'h0000, 5'b00000, 3'd0},
            '{16'h1340, 1'b0, 3'b000, decode_pkg::ALU_ADD,   16'h0000, 5'b00010, 3'd0},
            '{16'hF93F, 1'b0, 3'b000, decode_pkg::ALU_ADD,   16'h0000, 5'b00010, 3'd0},
            '{16'h97E0, 1'b0, 3'b000, decode_pkg::ALU_ADD,   16'h0000, 5'b00010, 3'd0},
            '{16'h826F, 1'b0, 3'b100, decode_pkg::ALU_ADD,   16'h000F, 5'b01000, 3'd0},
            '{16'h4360, 1'b0, 3'b100, decode_pkg::ALU_ADD,   16'h0000, 5'b00100, 3'd3},
            '{16'h43CA, 1'b0, 3'b100, decode_pkg::ALU_ADD,   16'h000A, 5'b00101, 3'd6},
            '{16'h4A3F, 1'b0, 3'b100, decode_pkg::ALU_SUB,   16'hFFFF, 5'b00100, 3'd1},
            '{16'h5600, 1'b0, 3'b100, decode_pkg::ALU_XOR,   16'h0000, 5'b00101, 3'd0},
            '{16'h0BC0, 1'b0, 3'b000, decode_pkg::ALU_ADD,   16'h0000, 5'b00000, 3'd0},
            '{16'h0900, 1'b0, 3'b000, decode_pkg::ALU_ADD,   16'h0000, 5'b00001, 3'd0},
            '{16'h0CA0, 1'b0, 3'b000, decode_pkg::ALU_ADD,   16'h0000, 5'b00000, 3'd0},
            '{16'h0FC0, 1'b0, 3'b000, decode_pkg::ALU_ADD,   16'h0000, 5'b00000, 3'd0}
        };

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        // Bubble in the first cycle after reset
        instr <= 16'h0800;

        for (int i = 0; i < NUM_ROWS; i++) begin
            row = stimTable[i];
            drawWord(word);
            @(posedge clk);
            instr <= row.instr;
            nopMech <= row.nopMech;
            wbData <= word;
            // Mid-cycle, after the combinational outputs settle
            @(negedge clk);
            rowIndex = i;
            checkRow(row, word);
            updateModel(row, word);
        end

        @(posedge clk);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+hw
hw/decode_pkg.sv
hw/instrDecoder.sv
hw/wbStage.sv
hw/regFileBypass.sv
hw/decodeStage.sv
testbench/decodeStage_chk.sv
testbench/tb_decodeStage.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_decodeStage \
    -f files.f \
    -o simDecode

# Keep going after a fatal exit so the output can still be searched
status=0
output=$(./obj_dir/simDecode 2>&1) || status=$?
echo "$output"

if echo "$output" | grep -q "Simulation finished: PASS"; then
    echo "run.sh: decode stage simulation passed"
    exit 0
fi

echo "run.sh: decode stage simulation failed (exit status $status)"
exit 1
